// File: src/dcache_mem_pkg.sv
// geometry is fixed here (2 ways, 4 words per line, 16 sets); changing it needs matching struct widths
`default_nettype none

package dcache_mem_pkg;

  //////////////////////////////////////////////////
  // cache geometry
  //////////////////////////////////////////////////

  localparam int unsigned XLEN           = 32;
  localparam int unsigned WORD_BYTES     = XLEN / 8;
  localparam int unsigned NUM_WAYS       = 2;
  localparam int unsigned NUM_BANKS      = 4;
  localparam int unsigned IDX_WIDTH      = 4;
  localparam int unsigned OFF_WIDTH      = 4;
  // upper offset bits pick the word, so they pick the bank
  localparam int unsigned BANK_SEL_WIDTH = 2;
  localparam int unsigned TAG_WIDTH      = 8;
  localparam int unsigned LINE_WIDTH     = NUM_BANKS * XLEN;
  localparam int unsigned NUM_SETS       = 1 << IDX_WIDTH;

  typedef logic [NUM_WAYS-1:0]  way_vec_t;
  typedef logic [NUM_BANKS-1:0] bank_vec_t;

  //////////////////////////////////////////////////
  // port bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                 req;
    logic                 prio;      // 1 masks all low priority requests
    logic                 tag_only;  // tag and valid lookup only
    logic [IDX_WIDTH-1:0] idx;
    logic [OFF_WIDTH-1:0] off;
  } rd_port_t;

  typedef struct packed {
    logic                    vld;
    way_vec_t                we;
    logic [TAG_WIDTH-1:0]    tag;
    logic [IDX_WIDTH-1:0]    idx;
    logic [LINE_WIDTH-1:0]   data;
    logic [LINE_WIDTH/8-1:0] be;
    way_vec_t                vld_bits;
  } line_wr_t;

  typedef struct packed {
    way_vec_t              req;  // one-hot target way
    logic [IDX_WIDTH-1:0]  idx;
    logic [OFF_WIDTH-1:0]  off;
    logic [XLEN-1:0]       data;
    logic [WORD_BYTES-1:0] be;
  } word_wr_t;

  typedef struct packed {
    way_vec_t        vld_bits;
    way_vec_t        hit_oh;
    logic [XLEN-1:0] data;
  } rd_rsp_t;

  // word offset to bank select
  function automatic bank_vec_t bank_onehot(input logic [BANK_SEL_WIDTH-1:0] sel);
    bank_vec_t oh;
    oh      = '0;
    oh[sel] = 1'b1;
    return oh;
  endfunction

endpackage

`default_nettype wire

// File: src/sram_bank.sv
// single-port RAM, no reset; rdata_o changes only on a read and holds otherwise
`default_nettype none

module sram_bank #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned NumWords  = 16
) (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [$clog2(NumWords)-1:0]     addr_i,
  input  logic [(DataWidth+7)/8-1:0]      be_i,
  input  logic [DataWidth-1:0]            wdata_i,
  output logic [DataWidth-1:0]            rdata_o
);

  logic [DataWidth-1:0] mem_q [NumWords];

  // byte lanes, the top lane may be partial
  always_ff @(posedge clk_i) begin : p_mem
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < DataWidth; b++) begin
          if (be_i[b/8]) begin
            mem_q[addr_i][b] <= wdata_i[b];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/read_arbiter.sv
// round-robin read grant with high priority masking; no grant while hold_i is high
`default_nettype none

module read_arbiter #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  dcache_mem_pkg::rd_port_t [NumPorts-1:0] rd_port_i,
  input  logic                                    hold_i,
  output logic [NumPorts-1:0]                     rd_ack_o,
  output logic [((NumPorts > 1) ? $clog2(NumPorts) : 1)-1:0] sel_o,
  output logic                                    rd_go_o
);
  import dcache_mem_pkg::*;

  localparam int unsigned SelWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [NumPorts-1:0] req_all;
  logic [NumPorts-1:0] req_hi;
  logic [NumPorts-1:0] req_comp;
  logic [SelWidth-1:0] last_q;
  logic [SelWidth-1:0] sel;
  logic                found;

  always_comb begin : p_req
    for (int k = 0; k < NumPorts; k++) begin
      req_all[k] = rd_port_i[k].req;
      req_hi[k]  = rd_port_i[k].req & rd_port_i[k].prio;
    end
  end

  // high priority requests shut out the low priority ones
  assign req_comp = (|req_hi) ? req_hi : req_all;

  // search starts one past the last accepted grant and wraps
  always_comb begin : p_search
    int unsigned idx;
    found = 1'b0;
    sel   = '0;
    for (int unsigned i = 1; i <= NumPorts; i++) begin
      idx = int'(last_q) + i;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!found && req_comp[idx]) begin
        found = 1'b1;
        sel   = SelWidth'(idx);
      end
    end
  end

  assign rd_go_o = found & ~hold_i;
  assign sel_o   = sel;

  always_comb begin : p_ack
    for (int k = 0; k < NumPorts; k++) begin
      rd_ack_o[k] = rd_go_o && (sel == SelWidth'(k));
    end
  end

  // pointer starts at the last port so port 0 wins first
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr
    if (!rst_ni) begin
      last_q <= SelWidth'(NumPorts - 1);
    end else if (rd_go_o) begin
      last_q <= sel;
    end
  end

endmodule

`default_nettype wire

// File: src/bank_ctrl.sv
// bank and tag access steering; refill wins, a word write yields to a data read of its bank
`default_nettype none

module bank_ctrl #(
  parameter int unsigned NumPorts = 3
) (
  input  dcache_mem_pkg::rd_port_t [NumPorts-1:0]               rd_port_i,
  input  logic [((NumPorts > 1) ? $clog2(NumPorts) : 1)-1:0]   sel_i,
  input  logic                                                  rd_go_i,
  input  dcache_mem_pkg::line_wr_t                              line_wr_i,
  input  dcache_mem_pkg::word_wr_t                              word_wr_i,
  output logic                                                  wr_ack_o,
  output dcache_mem_pkg::bank_vec_t                             bank_req_o,
  output dcache_mem_pkg::bank_vec_t                             bank_we_o,
  output logic [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::IDX_WIDTH-1:0] bank_addr_o,
  output logic [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::NUM_WAYS-1:0]
               [dcache_mem_pkg::WORD_BYTES-1:0]                 bank_be_o,
  output logic [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::NUM_WAYS-1:0]
               [dcache_mem_pkg::XLEN-1:0]                       bank_wdata_o,
  output dcache_mem_pkg::way_vec_t                              tag_req_o,
  output logic                                                  tag_we_o,
  output logic [dcache_mem_pkg::IDX_WIDTH-1:0]                  tag_addr_o,
  output logic [dcache_mem_pkg::NUM_WAYS-1:0][dcache_mem_pkg::TAG_WIDTH:0] tag_wdata_o,
  output logic                                                  lookup_en_o,
  output logic [dcache_mem_pkg::IDX_WIDTH-1:0]                  lookup_idx_o,
  output logic [dcache_mem_pkg::OFF_WIDTH-1:0]                  lookup_off_o
);
  import dcache_mem_pkg::*;

  rd_port_t                  rd_sel;
  logic [BANK_SEL_WIDTH-1:0] rd_bank;
  logic [BANK_SEL_WIDTH-1:0] wr_bank;
  logic                      rd_data;
  logic                      collision;

  assign rd_sel  = rd_port_i[sel_i];
  assign rd_bank = rd_sel.off[OFF_WIDTH-1 -: BANK_SEL_WIDTH];
  assign wr_bank = word_wr_i.off[OFF_WIDTH-1 -: BANK_SEL_WIDTH];

  // tag-only reads never touch the data banks
  assign rd_data   = rd_go_i & ~rd_sel.tag_only;
  assign collision = rd_data & (rd_bank == wr_bank);
  assign wr_ack_o  = (|word_wr_i.req) & ~line_wr_i.vld & ~collision;

  //////////////////////////////////////////////////
  // data banks
  //////////////////////////////////////////////////

  always_comb begin : p_banks
    bank_req_o = '0;
    bank_we_o  = '0;
    bank_be_o  = '0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      bank_addr_o[k] = word_wr_i.idx;
      for (int w = 0; w < NUM_WAYS; w++) begin
        bank_wdata_o[k][w] = line_wr_i.vld ? line_wr_i.data[k*XLEN +: XLEN] : word_wr_i.data;
      end
    end

    if (line_wr_i.vld) begin
      // refill writes every bank of the enabled ways
      bank_req_o = {NUM_BANKS{|line_wr_i.we}};
      bank_we_o  = {NUM_BANKS{|line_wr_i.we}};
      for (int k = 0; k < NUM_BANKS; k++) begin
        bank_addr_o[k] = line_wr_i.idx;
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (line_wr_i.we[w]) begin
            bank_be_o[k][w] = line_wr_i.be[k*WORD_BYTES +: WORD_BYTES];
          end
        end
      end
    end else begin
      if (rd_data) begin
        bank_req_o           = bank_onehot(rd_bank);
        bank_addr_o[rd_bank] = rd_sel.idx;
      end
      if (wr_ack_o) begin
        bank_req_o = bank_req_o | bank_onehot(wr_bank);
        bank_we_o  = bank_onehot(wr_bank);
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (word_wr_i.req[w]) begin
            bank_be_o[wr_bank][w] = word_wr_i.be;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // tag arrays and lookup context
  //////////////////////////////////////////////////

  assign lookup_en_o  = rd_go_i;
  assign lookup_idx_o = rd_sel.idx;
  assign lookup_off_o = rd_sel.off;

  assign tag_we_o   = line_wr_i.vld;
  assign tag_addr_o = line_wr_i.vld ? line_wr_i.idx : lookup_idx_o;
  // a read looks at every way
  assign tag_req_o  = line_wr_i.vld ? line_wr_i.we : {NUM_WAYS{rd_go_i}};

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_tag_wdata
    assign tag_wdata_o[w] = {line_wr_i.vld_bits[w], line_wr_i.tag};
  end

endmodule

`default_nettype wire

// File: src/hit_select.sv
// tag compare one cycle after grant; data is only meaningful when hit_oh is non-zero
`default_nettype none

module hit_select #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_ni,
  input  logic                                                  lookup_en_i,
  input  logic [dcache_mem_pkg::OFF_WIDTH-1:0]                  lookup_off_i,
  input  logic [NumPorts-1:0][dcache_mem_pkg::TAG_WIDTH-1:0]    rd_tag_i,
  input  logic [((NumPorts > 1) ? $clog2(NumPorts) : 1)-1:0]   sel_i,
  input  logic [dcache_mem_pkg::NUM_WAYS-1:0][dcache_mem_pkg::TAG_WIDTH:0] tag_rdata_i,
  input  logic [dcache_mem_pkg::NUM_BANKS-1:0][dcache_mem_pkg::NUM_WAYS-1:0]
               [dcache_mem_pkg::XLEN-1:0]                       bank_rdata_i,
  output dcache_mem_pkg::rd_rsp_t                               rd_rsp_o
);
  import dcache_mem_pkg::*;

  localparam int unsigned SelWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic                      en_q;
  logic [BANK_SEL_WIDTH-1:0] bank_q;
  logic [SelWidth-1:0]       sel_q;

  logic [TAG_WIDTH-1:0]      cmp_tag;
  way_vec_t                  vld_bits;
  way_vec_t                  hit_oh;
  logic [XLEN-1:0]           hit_word;

  //////////////////////////////////////////////////
  // lookup context
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctx
    if (!rst_ni) begin
      en_q   <= 1'b0;
      bank_q <= '0;
      sel_q  <= '0;
    end else begin
      en_q <= lookup_en_i;
      if (lookup_en_i) begin
        bank_q <= lookup_off_i[OFF_WIDTH-1 -: BANK_SEL_WIDTH];
        sel_q  <= sel_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // compare and select
  //////////////////////////////////////////////////

  // the tag of the port granted last cycle
  assign cmp_tag = rd_tag_i[sel_q];

  always_comb begin : p_cmp
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      vld_bits[w] = tag_rdata_i[w][TAG_WIDTH];
      hit_oh[w]   = en_q & vld_bits[w] & (tag_rdata_i[w][TAG_WIDTH-1:0] == cmp_tag);
      // and-or mux over the one-hot hit
      if (hit_oh[w]) begin
        hit_word = hit_word | bank_rdata_i[bank_q][w];
      end
    end
  end

  assign rd_rsp_o.vld_bits = vld_bits;
  assign rd_rsp_o.hit_oh   = hit_oh;
  assign rd_rsp_o.data     = hit_word;

endmodule

`default_nettype wire

// File: src/dcache_mem.sv
// write-through L1 data cache arrays; one lookup in flight, the tag arrives one cycle after rd_ack_o
`default_nettype none

module dcache_mem #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  dcache_mem_pkg::rd_port_t [NumPorts-1:0]         rd_port_i,
  input  logic [NumPorts-1:0][dcache_mem_pkg::TAG_WIDTH-1:0] rd_tag_i,
  output logic [NumPorts-1:0]                             rd_ack_o,
  output dcache_mem_pkg::rd_rsp_t                         rd_rsp_o,
  input  dcache_mem_pkg::line_wr_t                        line_wr_i,
  input  dcache_mem_pkg::word_wr_t                        word_wr_i,
  output logic                                            wr_ack_o
);
  import dcache_mem_pkg::*;

  localparam int unsigned SelWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [SelWidth-1:0] sel;
  logic                rd_go;

  bank_vec_t                                              bank_req;
  bank_vec_t                                              bank_we;
  logic [NUM_BANKS-1:0][IDX_WIDTH-1:0]                    bank_addr;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][WORD_BYTES-1:0]     bank_be;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][XLEN-1:0]           bank_wdata;
  logic [NUM_BANKS-1:0][NUM_WAYS-1:0][XLEN-1:0]           bank_rdata;

  way_vec_t                                               tag_req;
  logic                                                   tag_we;
  logic [IDX_WIDTH-1:0]                                   tag_addr;
  logic [NUM_WAYS-1:0][TAG_WIDTH:0]                       tag_wdata;
  logic [NUM_WAYS-1:0][TAG_WIDTH:0]                       tag_rdata;

  logic                                                   lookup_en;
  logic [OFF_WIDTH-1:0]                                   lookup_off;

  read_arbiter #(
    .NumPorts (NumPorts)
  ) i_read_arbiter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_port_i (rd_port_i),
    .hold_i    (line_wr_i.vld),
    .rd_ack_o  (rd_ack_o),
    .sel_o     (sel),
    .rd_go_o   (rd_go)
  );

  bank_ctrl #(
    .NumPorts (NumPorts)
  ) i_bank_ctrl (
    .rd_port_i    (rd_port_i),
    .sel_i        (sel),
    .rd_go_i      (rd_go),
    .line_wr_i    (line_wr_i),
    .word_wr_i    (word_wr_i),
    .wr_ack_o     (wr_ack_o),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_addr_o  (bank_addr),
    .bank_be_o    (bank_be),
    .bank_wdata_o (bank_wdata),
    .tag_req_o    (tag_req),
    .tag_we_o     (tag_we),
    .tag_addr_o   (tag_addr),
    .tag_wdata_o  (tag_wdata),
    .lookup_en_o  (lookup_en),
    .lookup_idx_o (),
    .lookup_off_o (lookup_off)
  );

  // one bank per word offset, each bank holds that word of every way
  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_data_banks
    sram_bank #(
      .DataWidth (NUM_WAYS * XLEN),
      .NumWords  (NUM_SETS)
    ) i_data_bank (
      .clk_i   (clk_i),
      .req_i   (bank_req[k]),
      .we_i    (bank_we[k]),
      .addr_i  (bank_addr[k]),
      .be_i    (bank_be[k]),
      .wdata_i (bank_wdata[k]),
      .rdata_o (bank_rdata[k])
    );
  end

  // tag with the valid bit on top
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_tag_banks
    sram_bank #(
      .DataWidth (TAG_WIDTH + 1),
      .NumWords  (NUM_SETS)
    ) i_tag_bank (
      .clk_i   (clk_i),
      .req_i   (tag_req[w]),
      .we_i    (tag_we),
      .addr_i  (tag_addr),
      .be_i    ('1),
      .wdata_i (tag_wdata[w]),
      .rdata_o (tag_rdata[w])
    );
  end

  hit_select #(
    .NumPorts (NumPorts)
  ) i_hit_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lookup_en_i  (lookup_en),
    .lookup_off_i (lookup_off),
    .rd_tag_i     (rd_tag_i),
    .sel_i        (sel),
    .tag_rdata_i  (tag_rdata),
    .bank_rdata_i (bank_rdata),
    .rd_rsp_o     (rd_rsp_o)
  );

endmodule

`default_nettype wire

// File: test/tb_dcache_mem.sv
// needs the 2-way, 4-word, 16-set geometry; only sets 0 to 7 are filled, the rest stay unknown
`default_nettype none

module tb_dcache_mem;
  timeunit 1ns;
  timeprecision 100ps;
  import dcache_mem_pkg::*;

  localparam int NumPorts   = 3;
  localparam int HalfPeriod = 4;
  localparam int DriveDelay = 1;
  // the tests need a few hundred cycles
  localparam int CycleLimit = 2000;
  localparam logic [TAG_WIDTH-1:0] MissTag = 8'h3c;

  logic                               clk_i = 1'b0;
  logic                               rst_ni;
  rd_port_t [NumPorts-1:0]            rd_port;
  logic [NumPorts-1:0][TAG_WIDTH-1:0] rd_tag;
  logic [NumPorts-1:0]                rd_ack;
  rd_rsp_t                            rd_rsp;
  line_wr_t                           line_wr;
  word_wr_t                           word_wr;
  logic                               wr_ack;

  // shadow model of the tag, valid and data arrays
  logic [TAG_WIDTH-1:0] tag_m  [NUM_SETS][NUM_WAYS];
  logic                 vld_m  [NUM_SETS][NUM_WAYS];
  logic [XLEN-1:0]      data_m [NUM_SETS][NUM_WAYS][NUM_BANKS];
  int                   ptr_m;
  logic [31:0]          seed = 32'h6fe15573;
  int                   checks;
  int                   mismatches;
  int                   errors;
  int                   cycles;

  dcache_mem #(
    .NumPorts (NumPorts)
  ) dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_port_i (rd_port),
    .rd_tag_i  (rd_tag),
    .rd_ack_o  (rd_ack),
    .rd_rsp_o  (rd_rsp),
    .line_wr_i (line_wr),
    .word_wr_i (word_wr),
    .wr_ack_o  (wr_ack)
  );

  always #(HalfPeriod) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // bit 7 set on every stored tag, so MissTag never hits
  function automatic logic [TAG_WIDTH-1:0] tag_of(input int s, input int way);
    return 8'h80 | TAG_WIDTH'(s << 1) | TAG_WIDTH'(way);
  endfunction

  function automatic rd_port_t make_req(input logic prio, input logic tag_only,
                                        input logic [IDX_WIDTH-1:0] idx,
                                        input logic [OFF_WIDTH-1:0] off);
    rd_port_t r;
    r.req      = 1'b1;
    r.prio     = prio;
    r.tag_only = tag_only;
    r.idx      = idx;
    r.off      = off;
    return r;
  endfunction

  function automatic rd_port_t random_req();
    logic [31:0] r;
    r = next_rand();
    return make_req(r[20], r[22:21] == 2'b00, IDX_WIDTH'(r[26:24]), {r[29:28], 2'b00});
  endfunction

  function automatic word_wr_t make_write(input int way, input logic [IDX_WIDTH-1:0] idx,
                                          input logic [OFF_WIDTH-1:0] off,
                                          input logic [XLEN-1:0] data,
                                          input logic [WORD_BYTES-1:0] be);
    word_wr_t w;
    w.req  = way_vec_t'(1 << way);
    w.idx  = idx;
    w.off  = off;
    w.data = data;
    w.be   = be;
    return w;
  endfunction

  function automatic logic any_request();
    logic any;
    any = 1'b0;
    for (int p = 0; p < NumPorts; p++) begin
      any = any | rd_port[p].req;
    end
    return any;
  endfunction

  // high priority masks low, then first requester after the last winner
  function automatic int expected_winner(input rd_port_t [NumPorts-1:0] reqs, input int last);
    logic [NumPorts-1:0] all_req;
    logic [NumPorts-1:0] hi_req;
    logic [NumPorts-1:0] comp;
    int idx;
    int win;
    for (int p = 0; p < NumPorts; p++) begin
      all_req[p] = reqs[p].req;
      hi_req[p]  = reqs[p].req & reqs[p].prio;
    end
    comp = (|hi_req) ? hi_req : all_req;
    win  = -1;
    for (int i = 1; i <= NumPorts; i++) begin
      idx = (last + i) % NumPorts;
      if (win < 0 && comp[idx]) begin
        win = idx;
      end
    end
    return win;
  endfunction

  function automatic way_vec_t expected_hit(input logic [IDX_WIDTH-1:0] idx,
                                            input logic [TAG_WIDTH-1:0] tag);
    way_vec_t h;
    for (int w = 0; w < NUM_WAYS; w++) begin
      h[w] = vld_m[idx][w] && (tag_m[idx][w] == tag);
    end
    return h;
  endfunction

  task automatic merge_word(input word_wr_t ww);
    logic [BANK_SEL_WIDTH-1:0] bank;
    bank = ww.off[OFF_WIDTH-1 -: BANK_SEL_WIDTH];
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (ww.req[w] && ww.be[b]) begin
          data_m[ww.idx][w][bank][8*b +: 8] = ww.data[8*b +: 8];
        end
      end
    end
  endtask

  task automatic count_mismatch(input string name, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
    mismatches++;
    $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, act);
  endtask

  task automatic raise_error(input string msg);
    errors++;
    $display("error: %s", msg);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #(DriveDelay);
  endtask

  task automatic check_rsp(input string name, input logic [IDX_WIDTH-1:0] idx,
                           input logic [OFF_WIDTH-1:0] off, input logic [TAG_WIDTH-1:0] tag,
                           input logic with_data);
    way_vec_t        hit;
    way_vec_t        vld;
    logic [XLEN-1:0] word;
    hit  = expected_hit(idx, tag);
    word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      vld[w] = vld_m[idx][w];
      if (hit[w]) begin
        word = data_m[idx][w][off[OFF_WIDTH-1 -: BANK_SEL_WIDTH]];
      end
    end
    checks++;
    assert (rd_rsp.hit_oh === hit) else count_mismatch(name, "hit_oh", hit, rd_rsp.hit_oh);
    assert (rd_rsp.vld_bits === vld) else count_mismatch(name, "vld_bits", vld, rd_rsp.vld_bits);
    if (with_data && (|hit)) begin
      assert (rd_rsp.data === word) else count_mismatch(name, "data", word, rd_rsp.data);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  task automatic refill_line(input logic [IDX_WIDTH-1:0] idx, input int way, input int hold);
    line_wr_t lw;
    lw          = '0;
    lw.vld      = 1'b1;
    lw.we       = way_vec_t'(1 << way);
    lw.tag      = tag_of(idx, way);
    lw.idx      = idx;
    lw.be       = '1;
    lw.vld_bits = '1;
    for (int k = 0; k < NUM_BANKS; k++) begin
      lw.data[k*XLEN +: XLEN] = next_rand();
      data_m[idx][way][k]     = lw.data[k*XLEN +: XLEN];
    end
    tag_m[idx][way] = lw.tag;
    vld_m[idx][way] = 1'b1;
    line_wr         = lw;
    repeat (hold) begin
      @(negedge clk_i);
      assert (rd_ack === '0 && wr_ack === 1'b0)
        else raise_error("read or word write acknowledged while a refill was active");
      next_cycle();
    end
    line_wr = '0;
  endtask

  task automatic do_read(input string name, input int port, input logic [IDX_WIDTH-1:0] idx,
                         input logic [OFF_WIDTH-1:0] off, input logic [TAG_WIDTH-1:0] tag,
                         input logic tag_only);
    rd_port[port] = make_req(1'b0, tag_only, idx, off);
    @(negedge clk_i);
    while (rd_ack[port] !== 1'b1) begin
      @(negedge clk_i);
    end
    ptr_m = port;
    next_cycle();
    rd_port[port] = '0;
    rd_tag[port]  = tag;
    @(negedge clk_i);
    check_rsp(name, idx, off, tag, !tag_only);
    next_cycle();
  endtask

  task automatic write_word(input string name, input word_wr_t ww);
    word_wr = ww;
    @(negedge clk_i);
    assert (wr_ack === 1'b1) else raise_error({name, ": word write withheld with no read"});
    while (wr_ack !== 1'b1) begin
      @(negedge clk_i);
    end
    merge_word(ww);
    next_cycle();
    word_wr = '0;
  endtask

  // data read on port 0 of set 3 next to a word write into way 1 of set 3
  task automatic collide(input string name, input logic [OFF_WIDTH-1:0] rd_off,
                         input logic [OFF_WIDTH-1:0] wr_off, input logic tag_only);
    word_wr_t             ww;
    logic                 exp_wr;
    logic [TAG_WIDTH-1:0] tag;
    ww         = make_write(1, 4'd3, wr_off, next_rand(), 4'(next_rand() >> 28) | 4'b0001);
    exp_wr     = tag_only || (rd_off[3:2] != wr_off[3:2]);
    tag        = tag_m[3][1];
    rd_port[0] = make_req(1'b0, tag_only, 4'd3, rd_off);
    word_wr    = ww;
    @(negedge clk_i);
    assert (rd_ack === 3'b001) else count_mismatch(name, "rd_ack_o", 1, rd_ack);
    assert (wr_ack === exp_wr) else count_mismatch(name, "wr_ack_o", exp_wr, wr_ack);
    ptr_m = 0;
    if (exp_wr) begin
      merge_word(ww);
    end
    next_cycle();
    rd_port[0] = '0;
    rd_tag[0]  = tag;
    if (exp_wr) begin
      word_wr = '0;
    end
    @(negedge clk_i);
    check_rsp(name, 4'd3, rd_off, tag, !tag_only);
    if (!exp_wr) begin
      while (wr_ack !== 1'b1) begin
        @(negedge clk_i);
      end
      merge_word(ww);
    end
    next_cycle();
    word_wr = '0;
  endtask

  // all ports keep requesting; a winner takes a fresh random request
  task automatic run_arbitration(input int rounds);
    rd_port_t             pend_req;
    logic [TAG_WIDTH-1:0] pend_tag;
    logic                 pend;
    logic [NumPorts-1:0]  exp_ack;
    logic [31:0]          pick;
    int                   win;
    int                   r;
    for (int p = 0; p < NumPorts; p++) begin
      rd_port[p] = random_req();
    end
    pend = 1'b0;
    r    = 0;
    while (r < rounds || pend || any_request()) begin
      @(negedge clk_i);
      if (pend) begin
        check_rsp("arbitration", pend_req.idx, pend_req.off, pend_tag, !pend_req.tag_only);
      end
      win     = expected_winner(rd_port, ptr_m);
      exp_ack = '0;
      if (win >= 0) begin
        exp_ack[win] = 1'b1;
      end
      assert (rd_ack === exp_ack) else count_mismatch("arbitration", "rd_ack_o", exp_ack, rd_ack);
      pend = (win >= 0);
      if (pend) begin
        pend_req = rd_port[win];
        pick     = next_rand() % 3;
        pend_tag = (pick == 0) ? MissTag : tag_m[pend_req.idx][pick - 1];
        ptr_m    = win;
      end
      next_cycle();
      if (pend) begin
        rd_tag[win] = pend_tag;
        if (r < rounds) begin
          rd_port[win] = random_req();
        end else begin
          rd_port[win] = '0;
        end
      end
      r++;
    end
  endtask

  //////////////////////////////////////////////////
  // checks that hold in every cycle
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : p_invariants
    logic [NumPorts-1:0] hi_req;
    for (int p = 0; p < NumPorts; p++) begin
      hi_req[p] = rd_port[p].req & rd_port[p].prio;
    end
    if (rst_ni === 1'b1) begin
      assert ((rd_ack & (rd_ack - 1'b1)) == '0)
        else raise_error("read acknowledge is not one-hot");
      assert (!(|hi_req) || (rd_ack & ~hi_req) == '0)
        else raise_error("low priority read acknowledged while a high priority read waited");
      assert (!line_wr.vld || (rd_ack == '0 && wr_ack == 1'b0))
        else raise_error("acknowledge given during a refill");
    end
  end

  initial begin : p_timeout
    for (cycles = 0; cycles < CycleLimit; cycles++) begin
      @(posedge clk_i);
    end
    $display("timeout: run did not end within %0d cycles", CycleLimit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : p_main
    rst_ni  = 1'b0;
    rd_port = '0;
    rd_tag  = '0;
    line_wr = '0;
    word_wr = '0;
    ptr_m   = NumPorts - 1;
    repeat (4) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (rd_rsp.hit_oh === '0) else count_mismatch("reset", "hit_oh", 0, rd_rsp.hit_oh);
    assert (rd_ack === '0 && wr_ack === 1'b0)
      else raise_error("acknowledge seen with no request after reset");
    next_cycle();

    // refill then read hit
    for (int s = 0; s < 8; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        refill_line(IDX_WIDTH'(s), w, 1);
      end
    end
    for (int s = 0; s < 8; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        for (int k = 0; k < NUM_BANKS; k++) begin
          do_read("refill_hit", (s + k) % NumPorts, IDX_WIDTH'(s), OFF_WIDTH'(k << 2),
                  tag_m[s][w], 1'b0);
        end
      end
    end

    // miss and tag-only lookup
    do_read("miss", 1, 4'd3, 4'h4, MissTag, 1'b0);
    do_read("tag_only", 2, 4'd5, 4'h0, tag_m[5][1], 1'b1);

    run_arbitration(80);

    // refill precedence, the read and write go through once it drops
    rd_port[0] = make_req(1'b0, 1'b0, 4'd2, 4'h4);
    word_wr    = make_write(1, 4'd2, 4'h8, next_rand(), 4'b0011);
    refill_line(4'd6, 0, 3);
    @(negedge clk_i);
    assert (rd_ack === 3'b001) else count_mismatch("refill_precedence", "rd_ack_o", 1, rd_ack);
    assert (wr_ack === 1'b1) else count_mismatch("refill_precedence", "wr_ack_o", 1, wr_ack);
    ptr_m = 0;
    merge_word(word_wr);
    next_cycle();
    rd_port[0] = '0;
    rd_tag[0]  = tag_m[2][0];
    word_wr    = '0;
    @(negedge clk_i);
    check_rsp("refill_precedence", 4'd2, 4'h4, tag_m[2][0], 1'b1);
    next_cycle();

    // word writes and bank collisions
    write_word("write_alone", make_write(0, 4'd3, 4'h0, next_rand(), 4'b0101));
    collide("collide_same_bank", 4'h4, 4'h4, 1'b0);
    collide("collide_other_bank", 4'h4, 4'hc, 1'b0);
    collide("collide_tag_only", 4'h8, 4'h8, 1'b1);
    for (int k = 0; k < NUM_BANKS; k++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        do_read("merged_bytes", k % NumPorts, 4'd3, OFF_WIDTH'(k << 2), tag_m[3][w], 1'b0);
      end
    end

    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, errors);
    if (mismatches == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: dcache_mem.f
src/dcache_mem_pkg.sv
src/sram_bank.sv
src/read_arbiter.sv
src/bank_ctrl.sv
src/hit_select.sv
src/dcache_mem.sv
test/tb_dcache_mem.sv
